/* cache_pkg.sv */
package cache_pkg;

  // Cache geometry, shared by both caches
  // Sets per way
  localparam int ENTRIES_PER_WAY = 64;
  // Two ways, one LRU bit per set is enough
  localparam int WAYS = 2;
  // Index bits select one of the sets
  localparam int INDEX_W = 6;
  // Address bits 1:0 are the byte offset, the rest above the index is tag
  localparam int TAG_W = 32 - INDEX_W - 2;

  // CPU side request, held stable while valid is high
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    // Byte enables, zero for a load or a fetch
    logic [3:0]  wmask;
    // Set for an instruction fetch
    logic        instr;
  } cpu_req_t;

  // Shared memory bus request
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    // Zero mask means read
    logic [3:0]  wmask;
  } mem_req_t;

  // Instruction cache FSM
  typedef enum logic {
    IC_LOOKUP,
    IC_FILL
  } icache_state_e;

  // Data cache FSM
  typedef enum logic [1:0] {
    DC_LOOKUP,
    DC_FILL,
    DC_WRITE
  } dcache_state_e;

endpackage

/* icache.sv */
`timescale 1ns/10ps

module icache (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic [31:0]         addr_i,
  input  logic                valid_i,
  output logic [31:0]         rdata_o,
  output logic                ready_o,
  output cache_pkg::mem_req_t mem_req_o,
  output logic                mem_valid_o,
  input  logic [31:0]         mem_rdata_i,
  input  logic                mem_ready_i
);

  // Tag and data arrays, one word per line
  logic [cache_pkg::TAG_W-1:0] tag_q [cache_pkg::WAYS][cache_pkg::ENTRIES_PER_WAY];
  logic [31:0] data_q [cache_pkg::WAYS][cache_pkg::ENTRIES_PER_WAY];
  logic [cache_pkg::ENTRIES_PER_WAY-1:0] valid_q [cache_pkg::WAYS];
  // Per set, the way to replace next
  logic [cache_pkg::ENTRIES_PER_WAY-1:0] lru_q;

  cache_pkg::icache_state_e state_q;
  logic                          ready_q;
  logic                          mem_valid_q;
  logic [31:0]                   rdata_q;
  logic [31:0]                   fill_addr_q;
  logic                          fill_way_q;

  logic [cache_pkg::INDEX_W-1:0] idx;
  logic [cache_pkg::TAG_W-1:0]   tag;
  logic [cache_pkg::INDEX_W-1:0] fill_idx;
  logic [cache_pkg::TAG_W-1:0]   fill_tag;
  logic [cache_pkg::WAYS-1:0]    way_hit;
  logic                          hit;
  logic                          hit_way;
  logic                          accept;
  logic                          fill_we;

  // Split the CPU address
  assign idx = addr_i[cache_pkg::INDEX_W+1:2];
  assign tag = addr_i[31:cache_pkg::INDEX_W+2];
  // Same split on the latched miss address
  assign fill_idx = fill_addr_q[cache_pkg::INDEX_W+1:2];
  assign fill_tag = fill_addr_q[31:cache_pkg::INDEX_W+2];

  // Tag compare in both ways
  always_comb begin
    for (int w = 0; w < cache_pkg::WAYS; w++) begin
      way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == tag);
    end
  end

  assign hit     = |way_hit;
  assign hit_way = way_hit[1];

  // New request only while ready is not already pulsing
  assign accept  = (state_q == cache_pkg::IC_LOOKUP) && valid_i && !ready_q;
  assign fill_we = (state_q == cache_pkg::IC_FILL) && mem_ready_i;

  // Control FSM
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= cache_pkg::IC_LOOKUP;
      ready_q     <= 1'b0;
      mem_valid_q <= 1'b0;
      lru_q       <= '0;
      for (int w = 0; w < cache_pkg::WAYS; w++) begin
        valid_q[w] <= '0;
      end
    end else begin
      // Ready is a single cycle pulse
      ready_q <= 1'b0;
      case (state_q)
        cache_pkg::IC_LOOKUP: begin
          if (accept) begin
            if (hit) begin
              ready_q    <= 1'b1;
              // Point away from the way just used
              lru_q[idx] <= ~hit_way;
            end else begin
              // Bus read goes out the next cycle
              mem_valid_q <= 1'b1;
              state_q     <= cache_pkg::IC_FILL;
            end
          end
        end
        cache_pkg::IC_FILL: begin
          // Hold the bus request until memory answers
          if (mem_ready_i) begin
            mem_valid_q                 <= 1'b0;
            ready_q                     <= 1'b1;
            valid_q[fill_way_q][fill_idx] <= 1'b1;
            lru_q[fill_idx]             <= ~fill_way_q;
            state_q                     <= cache_pkg::IC_LOOKUP;
          end
        end
        default: state_q <= cache_pkg::IC_LOOKUP;
      endcase
    end
  end

  // Arrays and payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q     <= data_q[hit_way][idx];
      fill_addr_q <= addr_i;
      // Victim is the LRU way of this set
      fill_way_q  <= lru_q[idx];
    end
    if (fill_we) begin
      rdata_q                      <= mem_rdata_i;
      tag_q[fill_way_q][fill_idx]  <= fill_tag;
      data_q[fill_way_q][fill_idx] <= mem_rdata_i;
    end
  end

  assign rdata_o     = rdata_q;
  assign ready_o     = ready_q;
  assign mem_valid_o = mem_valid_q;
  // Read only, word aligned
  assign mem_req_o   = '{addr: {fill_addr_q[31:2], 2'b00}, wdata: 32'h0, wmask: 4'h0};

endmodule

/* dcache.sv */
`timescale 1ns/10ps

module dcache (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  cache_pkg::cpu_req_t req_i,
  input  logic                valid_i,
  output logic [31:0]         rdata_o,
  output logic                ready_o,
  output cache_pkg::mem_req_t mem_req_o,
  output logic                mem_valid_o,
  input  logic [31:0]         mem_rdata_i,
  input  logic                mem_ready_i
);

  // Tag and data arrays, one word per line
  logic [cache_pkg::TAG_W-1:0] tag_q [cache_pkg::WAYS][cache_pkg::ENTRIES_PER_WAY];
  logic [31:0] data_q [cache_pkg::WAYS][cache_pkg::ENTRIES_PER_WAY];
  logic [cache_pkg::ENTRIES_PER_WAY-1:0] valid_q [cache_pkg::WAYS];
  // Per set, the way to replace next
  logic [cache_pkg::ENTRIES_PER_WAY-1:0] lru_q;

  cache_pkg::dcache_state_e state_q;
  logic                          ready_q;
  logic                          mem_valid_q;
  logic [31:0]                   rdata_q;
  cache_pkg::cpu_req_t           req_q;
  // Fill victim on a load miss, hit way on a store
  logic                          way_q;
  logic                          hit_q;

  logic [cache_pkg::INDEX_W-1:0] idx;
  logic [cache_pkg::TAG_W-1:0]   tag;
  logic [cache_pkg::INDEX_W-1:0] req_idx;
  logic [cache_pkg::TAG_W-1:0]   req_tag;
  logic [cache_pkg::WAYS-1:0]    way_hit;
  logic                          hit;
  logic                          hit_way;
  logic                          is_store;
  logic                          accept;
  logic                          fill_we;
  logic                          store_we;

  // Byte merge of store data into an old word
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  mask);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign idx     = req_i.addr[cache_pkg::INDEX_W+1:2];
  assign tag     = req_i.addr[31:cache_pkg::INDEX_W+2];
  assign req_idx = req_q.addr[cache_pkg::INDEX_W+1:2];
  assign req_tag = req_q.addr[31:cache_pkg::INDEX_W+2];

  // Tag compare in both ways
  always_comb begin
    for (int w = 0; w < cache_pkg::WAYS; w++) begin
      way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == tag);
    end
  end

  assign hit      = |way_hit;
  assign hit_way  = way_hit[1];
  // Any byte enable makes it a store
  assign is_store = |req_i.wmask;

  assign accept   = (state_q == cache_pkg::DC_LOOKUP) && valid_i && !ready_q;
  assign fill_we  = (state_q == cache_pkg::DC_FILL) && mem_ready_i;
  // Write-through, the line only changes if it was present
  assign store_we = (state_q == cache_pkg::DC_WRITE) && mem_ready_i && hit_q;

  // Control FSM
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= cache_pkg::DC_LOOKUP;
      ready_q     <= 1'b0;
      mem_valid_q <= 1'b0;
      lru_q       <= '0;
      for (int w = 0; w < cache_pkg::WAYS; w++) begin
        valid_q[w] <= '0;
      end
    end else begin
      ready_q <= 1'b0;
      case (state_q)
        cache_pkg::DC_LOOKUP: begin
          if (accept) begin
            if (is_store) begin
              // Every store goes to memory
              mem_valid_q <= 1'b1;
              state_q     <= cache_pkg::DC_WRITE;
            end else if (hit) begin
              ready_q    <= 1'b1;
              lru_q[idx] <= ~hit_way;
            end else begin
              mem_valid_q <= 1'b1;
              state_q     <= cache_pkg::DC_FILL;
            end
          end
        end
        cache_pkg::DC_FILL: begin
          if (mem_ready_i) begin
            mem_valid_q              <= 1'b0;
            ready_q                  <= 1'b1;
            valid_q[way_q][req_idx]  <= 1'b1;
            lru_q[req_idx]           <= ~way_q;
            state_q                  <= cache_pkg::DC_LOOKUP;
          end
        end
        cache_pkg::DC_WRITE: begin
          if (mem_ready_i) begin
            mem_valid_q <= 1'b0;
            ready_q     <= 1'b1;
            // No allocate on a store miss
            if (hit_q) begin
              lru_q[req_idx] <= ~way_q;
            end
            state_q <= cache_pkg::DC_LOOKUP;
          end
        end
        default: state_q <= cache_pkg::DC_LOOKUP;
      endcase
    end
  end

  // Arrays and payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= data_q[hit_way][idx];
      req_q   <= req_i;
      hit_q   <= hit;
      way_q   <= (is_store && hit) ? hit_way : lru_q[idx];
    end
    if (fill_we) begin
      rdata_q                <= mem_rdata_i;
      tag_q[way_q][req_idx]  <= req_tag;
      data_q[way_q][req_idx] <= mem_rdata_i;
    end
    if (store_we) begin
      data_q[way_q][req_idx] <= merge_bytes(data_q[way_q][req_idx], req_q.wdata, req_q.wmask);
    end
  end

  assign rdata_o     = rdata_q;
  assign ready_o     = ready_q;
  assign mem_valid_o = mem_valid_q;
  // Load requests carry a zero mask, so the bus sees a read
  assign mem_req_o   = '{addr: {req_q.addr[31:2], 2'b00}, wdata: req_q.wdata,
                         wmask: req_q.wmask};

endmodule

/* cache_steer.sv */
`timescale 1ns/10ps

module cache_steer (
  input  cache_pkg::cpu_req_t cpu_req_i,
  input  logic                cpu_valid_i,
  output logic [31:0]         cpu_rdata_o,
  output logic                cpu_ready_o,
  // Instruction cache side
  output logic                ic_valid_o,
  input  logic [31:0]         ic_rdata_i,
  input  logic                ic_ready_i,
  input  cache_pkg::mem_req_t ic_mem_req_i,
  input  logic                ic_mem_valid_i,
  output logic                ic_mem_ready_o,
  // Data cache side
  output logic                dc_valid_o,
  input  logic [31:0]         dc_rdata_i,
  input  logic                dc_ready_i,
  input  cache_pkg::mem_req_t dc_mem_req_i,
  input  logic                dc_mem_valid_i,
  output logic                dc_mem_ready_o,
  // Shared memory bus
  output cache_pkg::mem_req_t mem_req_o,
  output logic                mem_valid_o,
  input  logic                mem_ready_i
);

  // Instruction flag picks the cache, the other one stays idle
  always_comb begin
    ic_valid_o     = 1'b0;
    ic_mem_ready_o = 1'b0;
    dc_valid_o     = 1'b0;
    dc_mem_ready_o = 1'b0;
    if (cpu_req_i.instr) begin
      // Fetch path
      ic_valid_o     = cpu_valid_i;
      cpu_rdata_o    = ic_rdata_i;
      cpu_ready_o    = ic_ready_i;
      mem_req_o      = ic_mem_req_i;
      mem_valid_o    = ic_mem_valid_i;
      ic_mem_ready_o = mem_ready_i;
    end else begin
      // Load and store path
      dc_valid_o     = cpu_valid_i;
      cpu_rdata_o    = dc_rdata_i;
      cpu_ready_o    = dc_ready_i;
      mem_req_o      = dc_mem_req_i;
      mem_valid_o    = dc_mem_valid_i;
      dc_mem_ready_o = mem_ready_i;
    end
  end

endmodule

/* cache_top.sv */
`timescale 1ns/10ps

module cache_top (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  cache_pkg::cpu_req_t cpu_req_i,
  input  logic                cpu_valid_i,
  output logic [31:0]         cpu_rdata_o,
  output logic                cpu_ready_o,
  output cache_pkg::mem_req_t mem_req_o,
  output logic                mem_valid_o,
  input  logic [31:0]         mem_rdata_i,
  input  logic                mem_ready_i
);

  // Instruction cache wires
  logic                ic_valid, ic_ready, ic_mem_valid, ic_mem_ready;
  logic [31:0]         ic_rdata;
  cache_pkg::mem_req_t ic_mem_req;
  // Data cache wires
  logic                dc_valid, dc_ready, dc_mem_valid, dc_mem_ready;
  logic [31:0]         dc_rdata;
  cache_pkg::mem_req_t dc_mem_req;

  cache_steer i_steer (
    .cpu_req_i(cpu_req_i), .cpu_valid_i(cpu_valid_i),
    .cpu_rdata_o(cpu_rdata_o), .cpu_ready_o(cpu_ready_o),
    .ic_valid_o(ic_valid), .ic_rdata_i(ic_rdata), .ic_ready_i(ic_ready),
    .ic_mem_req_i(ic_mem_req), .ic_mem_valid_i(ic_mem_valid), .ic_mem_ready_o(ic_mem_ready),
    .dc_valid_o(dc_valid), .dc_rdata_i(dc_rdata), .dc_ready_i(dc_ready),
    .dc_mem_req_i(dc_mem_req), .dc_mem_valid_i(dc_mem_valid), .dc_mem_ready_o(dc_mem_ready),
    .mem_req_o(mem_req_o), .mem_valid_o(mem_valid_o), .mem_ready_i(mem_ready_i)
  );

  // Read data from memory goes straight to both caches
  icache i_icache (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .addr_i(cpu_req_i.addr), .valid_i(ic_valid),
    .rdata_o(ic_rdata), .ready_o(ic_ready), .mem_req_o(ic_mem_req),
    .mem_valid_o(ic_mem_valid), .mem_rdata_i(mem_rdata_i), .mem_ready_i(ic_mem_ready)
  );

  dcache i_dcache (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .req_i(cpu_req_i), .valid_i(dc_valid),
    .rdata_o(dc_rdata), .ready_o(dc_ready), .mem_req_o(dc_mem_req),
    .mem_valid_o(dc_mem_valid), .mem_rdata_i(mem_rdata_i), .mem_ready_i(dc_mem_ready)
  );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held for 8 cycles, released on a falling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

/* tb_mem.sv */
`timescale 1ns/10ps

module tb_mem (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  cache_pkg::mem_req_t mem_req_i,
  input  logic                mem_valid_i,
  output logic [31:0]         mem_rdata_o,
  output logic                mem_ready_o,
  output int                  reads_o,
  output int                  writes_o
);

  // 4 KB of words, every test address stays below 0x1000
  logic [31:0] mem [1024];
  // Random source for the ready delay
  logic [31:0] lfsr = 32'h8361;
  logic [1:0]  delay;
  logic [1:0]  wait_cnt = 2'd0;
  logic        pending = 1'b0;
  logic        ready_q = 1'b0;
  logic [31:0] rdata_q = 32'h0;
  logic [9:0]  idx;

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  assign idx = mem_req_i.addr[11:2];

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ready_q  <= 1'b0;
      pending  <= 1'b0;
      wait_cnt <= 2'd0;
      reads_o  <= 0;
      writes_o <= 0;
      // Power-up content is the word address XOR a fixed pattern
      for (int i = 0; i < 1024; i++) begin
        mem[i] <= (i << 2) ^ 32'hA5A5_0000;
      end
    end else begin
      ready_q <= 1'b0;
      if (mem_valid_i && !ready_q) begin
        if (!pending) begin
          // Two LFSR bits give 0 to 3 extra wait cycles
          delay[0] = lfsr[0];
          lfsr = lfsr_next(lfsr);
          delay[1] = lfsr[0];
          lfsr = lfsr_next(lfsr);
          pending  <= 1'b1;
          wait_cnt <= delay;
        end else if (wait_cnt != 2'd0) begin
          wait_cnt <= wait_cnt - 2'd1;
        end else begin
          pending <= 1'b0;
          ready_q <= 1'b1;
          if (mem_req_i.wmask == 4'h0) begin
            rdata_q <= mem[idx];
            reads_o <= reads_o + 1;
          end else begin
            // Only enabled bytes change
            for (int b = 0; b < 4; b++) begin
              if (mem_req_i.wmask[b]) begin
                mem[idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
              end
            end
            writes_o <= writes_o + 1;
          end
        end
      end
    end
  end

  assign mem_ready_o = ready_q;
  assign mem_rdata_o = rdata_q;

endmodule

/* tb_cache.sv */
`timescale 1ns/10ps

module tb_cache;

  logic                clk;
  logic                arst_n;
  cache_pkg::cpu_req_t cpu_req;
  logic                cpu_valid;
  logic [31:0]         cpu_rdata;
  logic                cpu_ready;
  cache_pkg::mem_req_t mem_req;
  logic                mem_valid;
  logic [31:0]         mem_rdata;
  logic                mem_ready;
  int                  mem_reads;
  int                  mem_writes;

  tb_clk_gen i_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

  tb_mem i_mem (
    .clk_i(clk), .arst_n_i(arst_n), .mem_req_i(mem_req), .mem_valid_i(mem_valid),
    .mem_rdata_o(mem_rdata), .mem_ready_o(mem_ready),
    .reads_o(mem_reads), .writes_o(mem_writes)
  );

  cache_top i_dut (
    .clk_i(clk), .arst_n_i(arst_n), .cpu_req_i(cpu_req), .cpu_valid_i(cpu_valid),
    .cpu_rdata_o(cpu_rdata), .cpu_ready_o(cpu_ready), .mem_req_o(mem_req),
    .mem_valid_o(mem_valid), .mem_rdata_i(mem_rdata), .mem_ready_i(mem_ready)
  );

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    if (got !== expected) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, expected);
      $display("Test failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "Run aborted");
  endtask

  // Runs one CPU request and returns its read data and latency
  // Also reports whether bus ready was high the cycle before cpu ready
  task automatic run_op(input logic [7:0] op, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] mask,
                        output logic [31:0] rdata, output int cycles,
                        output logic after_bus);
    cache_pkg::cpu_req_t req;
    logic                seen;
    logic                bus_ready_prev;
    req.addr  = addr;
    req.wdata = wdata;
    req.wmask = (op == "S") ? mask : 4'h0;
    req.instr = (op == "F");
    @(negedge clk);
    // Between requests ready is low and the bus is idle
    check_value(cpu_ready, 1'b0, $sformatf("cpu ready before %c %h", op, addr));
    check_value(mem_valid, 1'b0, $sformatf("bus valid before %c %h", op, addr));
    cpu_req        = req;
    cpu_valid      = 1'b1;
    cycles         = 0;
    seen           = 1'b0;
    bus_ready_prev = 1'b0;
    // Request held until ready shows up at a falling edge
    while (!seen) begin
      @(negedge clk);
      cycles++;
      if (cpu_ready === 1'b1) begin
        seen = 1'b1;
      end else if (cycles >= 50) begin
        abort_run($sformatf("Timeout: no cpu ready after 50 cycles for %c at %h", op, addr));
      end else begin
        bus_ready_prev = mem_ready;
      end
    end
    rdata     = cpu_rdata;
    after_bus = bus_ready_prev;
    cpu_valid = 1'b0;
  endtask

  initial begin
    int          fd;
    string       line;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  mask;
    logic [31:0] exp_data;
    logic [31:0] rdata;
    logic        after_bus;
    int          exp_reads;
    int          fields;
    int          reads_before;
    int          writes_before;
    int          cycles;
    int          op_count;
    int          waited;
    cpu_req   = '0;
    cpu_valid = 1'b0;
    op_count  = 0;
    waited    = 0;
    while (arst_n !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > 20) begin
        abort_run("Timeout: reset was never released");
      end
    end
    fd = $fopen("cache_input.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open cache_input.txt");
    end
    while ($fgets(line, fd) != 0) begin
      // Skip comments and short or blank lines
      if (line.len() > 8 && line[0] != "#") begin
        fields = $sscanf(line, "%c %h %h %h %h %d", op, addr, wdata, mask, exp_data,
                         exp_reads);
        if (fields != 6 || !(op == "F" || op == "L" || op == "S")) begin
          abort_run($sformatf("Malformed stimulus line: %s", line));
        end
        reads_before  = mem_reads;
        writes_before = mem_writes;
        run_op(op, addr, wdata, mask, rdata, cycles, after_bus);
        if (op != "S") begin
          check_value(rdata, exp_data, $sformatf("read data of %c %h", op, addr));
        end
        check_value(mem_reads - reads_before, exp_reads,
                    $sformatf("bus reads of %c %h", op, addr));
        // Every store and only a store is written through to the bus
        check_value(mem_writes - writes_before, (op == "S") ? 1 : 0,
                    $sformatf("bus writes of %c %h", op, addr));
        if (op != "S" && exp_reads == 0) begin
          // Hit answers in the cycle after valid
          check_value(cycles, 1, $sformatf("hit latency of %c %h", op, addr));
        end else begin
          // Bus access answers one cycle after bus ready
          check_value(after_bus, 1'b1,
                      $sformatf("ready after bus ready of %c %h", op, addr));
        end
        op_count++;
      end
    end
    $fclose(fd);
    if (op_count > 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("No operations found in cache_input.txt");
      $display("Test failed");
      $fatal(1, "Empty stimulus");
    end
  end

endmodule

/* build.f */
cache_pkg.sv
icache.sv
dcache.sv
cache_steer.sv
cache_top.sv
tb_clk_gen.sv
tb_mem.sv
tb_cache.sv

/* Bender.yml */
package:
  name: cache_subsystem

sources:
  - cache_pkg.sv
  - icache.sv
  - dcache.sv
  - cache_steer.sv
  - cache_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_mem.sv
      - tb_cache.sv

/* cache_input.txt */
# op addr data mask expected_data bus_reads   (op F fetch, L load, S store)
# data and mask apply to stores only, bus_reads is the expected read count change
F 00000100 00000000 0 a5a50100 1
F 00000100 00000000 0 a5a50100 0
L 00000100 00000000 0 a5a50100 1
L 00000200 00000000 0 a5a50200 1
L 00000200 00000000 0 a5a50200 0
S 00000200 11223344 3 00000000 0
L 00000200 00000000 0 a5a53344 0
F 00000200 00000000 0 a5a53344 1
S 00000304 deadbeef c 00000000 0
L 00000304 00000000 0 dead0304 1
L 00000304 00000000 0 dead0304 0
S 00000304 00000077 1 00000000 0
L 00000304 00000000 0 dead0377 0
L 00000040 00000000 0 a5a50040 1
L 00000140 00000000 0 a5a50140 1
L 00000040 00000000 0 a5a50040 0
L 00000240 00000000 0 a5a50240 1
L 00000040 00000000 0 a5a50040 0
L 00000140 00000000 0 a5a50140 1
F 00000080 00000000 0 a5a50080 1
F 00000180 00000000 0 a5a50180 1
F 00000280 00000000 0 a5a50280 1
F 00000180 00000000 0 a5a50180 0
F 00000080 00000000 0 a5a50080 1
